// File: Makefile
# Verilator flow for the AHB-Lite peripheral subsystem

VERILATOR ?= verilator
TOP       ?= tb_soc_periph
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --timescale 1ns/1ps
PASS_MSG  := TEST RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Fails unless the pass line shows up in the simulator output
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(BUILD_DIR)

// File: hw/ahb_addr_decode.sv
// Needs RAM_ADDR_BITS >= 4 since GPIO takes its offset from the low word-address bits
`timescale 1ns/1ps
`default_nettype none

module ahb_addr_decode #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  wire logic                       clk,
    input  wire logic                       RSTn,
    input  wire soc_bus_pkg::addr_t         i_haddr,
    input  wire soc_bus_pkg::htrans_t       i_htrans,
    input  wire logic                       i_hwrite,
    input  wire soc_bus_pkg::hsize_t        i_hsize,
    input  wire logic                       i_hready,
    output logic                            o_ram_sel,
    output logic                            o_gpio_sel,
    output logic                            o_err_sel,
    output logic                            o_wr_en,
    output soc_bus_pkg::strb_t              o_strb,
    output logic [RAM_ADDR_BITS-1:0]        o_word_addr,
    output logic                            o_ram_rd_en,
    output logic [RAM_ADDR_BITS-1:0]        o_ram_rd_addr
);

    import soc_bus_pkg::*;

    region_t                  region;
    logic                     accept;     // Address phase taken this edge
    logic                     ram_hit;
    logic                     gpio_hit;
    strb_t                    strb;
    logic [RAM_ADDR_BITS-1:0] word_addr;

    // ------------------------------
    // Address phase decode
    // ------------------------------
    assign region    = i_haddr[31:24];
    assign accept    = i_hready && i_htrans[1];   // NONSEQ or SEQ
    assign ram_hit   = (region == REGION_RAM);
    assign gpio_hit  = (region == REGION_GPIO);
    assign word_addr = i_haddr[RAM_ADDR_BITS+1:2];  // RAM aliases modulo depth

    // Byte lanes from size and low address bits
    always_comb
    begin
        case (i_hsize)
            HSIZE_BYTE: strb = strb_t'(4'b0001 << i_haddr[1:0]);
            HSIZE_HALF: strb = i_haddr[1] ? 4'b1100 : 4'b0011;
            HSIZE_WORD: strb = 4'b1111;
            default:    strb = 4'b1111;
        endcase
    end

    // RAM read starts here so its data lands in the data phase
    assign o_ram_rd_en   = accept && ram_hit && !i_hwrite;
    assign o_ram_rd_addr = word_addr;

    // ------------------------------
    // Data phase controls
    // ------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            o_ram_sel  <= 1'b0;
            o_gpio_sel <= 1'b0;
            o_err_sel  <= 1'b0;
            o_wr_en    <= 1'b0;
        end
        else if (accept)
        begin
            o_ram_sel  <= ram_hit;
            o_gpio_sel <= gpio_hit;
            o_err_sel  <= !ram_hit && !gpio_hit;   // Unmapped
            o_wr_en    <= i_hwrite;
        end
        else
        begin
            // Also drops the error select after its first cycle
            o_ram_sel  <= 1'b0;
            o_gpio_sel <= 1'b0;
            o_err_sel  <= 1'b0;
            o_wr_en    <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            o_strb      <= strb;
            o_word_addr <= word_addr;
        end
    end

endmodule

`default_nettype wire

// File: hw/ahb_gpio.sv
// GPIO_WIDTH 1..32, input pins are asynchronous and pass two sync flops before readback
`timescale 1ns/1ps
`default_nettype none

module ahb_gpio #(
    parameter int GPIO_WIDTH = 32
) (
    input  wire logic                       clk,
    input  wire logic                       RSTn,
    input  wire logic                       i_sel,
    input  wire logic                       i_wr_en,
    input  wire soc_bus_pkg::strb_t         i_strb,
    input  wire logic [3:0]                 i_reg_addr,
    input  wire soc_bus_pkg::data_t         i_wdata,
    input  wire logic [GPIO_WIDTH-1:0]      i_gpio_in,
    output soc_bus_pkg::data_t              o_rdata,
    output logic [GPIO_WIDTH-1:0]           o_gpio_out,
    output logic [GPIO_WIDTH-1:0]           o_gpio_oe
);

    import soc_bus_pkg::*;

    data_t                  lane_mask;      // Strobes widened to bits
    logic [GPIO_WIDTH-1:0]  wr_mask;
    logic [GPIO_WIDTH-1:0]  wr_bits;
    logic [GPIO_WIDTH-1:0]  in_meta;
    logic [GPIO_WIDTH-1:0]  in_sync;

    assign lane_mask = {{8{i_strb[3]}}, {8{i_strb[2]}}, {8{i_strb[1]}}, {8{i_strb[0]}}};
    assign wr_mask   = lane_mask[GPIO_WIDTH-1:0];
    assign wr_bits   = i_wdata[GPIO_WIDTH-1:0] & wr_mask;

    // ------------------------------
    // Output and enable registers
    // ------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            o_gpio_out <= '0;
            o_gpio_oe  <= '0;
        end
        else if (i_sel && i_wr_en)
        begin
            if (i_reg_addr == GPIO_REG_OUT)
                o_gpio_out <= (o_gpio_out & ~wr_mask) | wr_bits;
            if (i_reg_addr == GPIO_REG_OE)
                o_gpio_oe <= (o_gpio_oe & ~wr_mask) | wr_bits;
        end
    end

    // Two-flop input synchronizer
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
        begin
            in_meta <= '0;
            in_sync <= '0;
        end
        else
        begin
            in_meta <= i_gpio_in;
            in_sync <= in_meta;
        end
    end

    // ------------------------------
    // Read back, zero-extended
    // ------------------------------
    always_comb
    begin
        o_rdata = '0;
        case (i_reg_addr)
            GPIO_REG_OUT: o_rdata[GPIO_WIDTH-1:0] = o_gpio_out;
            GPIO_REG_OE:  o_rdata[GPIO_WIDTH-1:0] = o_gpio_oe;
            GPIO_REG_IN:  o_rdata[GPIO_WIDTH-1:0] = in_sync;
            default:      o_rdata = '0;     // Unused offsets
        endcase
    end

endmodule

`default_nettype wire

// File: hw/ahb_resp_mux.sv
// Zero wait states for mapped slaves, two-cycle ERROR for unmapped addresses
`timescale 1ns/1ps
`default_nettype none

module ahb_resp_mux (
    input  wire logic                   clk,
    input  wire logic                   RSTn,
    input  wire logic                   i_ram_sel,
    input  wire logic                   i_gpio_sel,
    input  wire logic                   i_err_sel,
    input  wire soc_bus_pkg::data_t     i_ram_rdata,
    input  wire soc_bus_pkg::data_t     i_gpio_rdata,
    output soc_bus_pkg::data_t          o_hrdata,
    output logic                        o_hready,
    output logic                        o_hresp
);

    typedef enum logic {
        RESP_OK,        // Normal, or first error cycle
        RESP_ERR2       // Second error cycle
    } resp_state_t;

    resp_state_t state;
    resp_state_t state_next;

    // ------------------------------
    // Read data select
    // ------------------------------
    always_comb
    begin
        if (i_ram_sel)
            o_hrdata = i_ram_rdata;
        else if (i_gpio_sel)
            o_hrdata = i_gpio_rdata;
        else
            o_hrdata = '0;
    end

    // ------------------------------
    // Error response FSM
    // ------------------------------
    always_comb
    begin
        state_next = state;
        case (state)
            RESP_OK:   if (i_err_sel) state_next = RESP_ERR2;
            RESP_ERR2: state_next = RESP_OK;
            default:   state_next = RESP_OK;
        endcase
    end

    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
            state <= RESP_OK;
        else
            state <= state_next;
    end

    // First cycle stalls, second completes, both flag ERROR
    assign o_hready = !((state == RESP_OK) && i_err_sel);
    assign o_hresp  = ((state == RESP_OK) && i_err_sel) || (state == RESP_ERR2);

endmodule

`default_nettype wire

// File: hw/ahb_sram.sv
// Inferred single-clock RAM, contents are undefined after power-up
`timescale 1ns/1ps
`default_nettype none

module ahb_sram #(
    parameter int RAM_ADDR_BITS = 10
) (
    input  wire logic                       clk,
    input  wire logic                       RSTn,
    input  wire logic                       i_sel,
    input  wire logic                       i_wr_en,
    input  wire soc_bus_pkg::strb_t         i_strb,
    input  wire logic [RAM_ADDR_BITS-1:0]   i_word_addr,
    input  wire soc_bus_pkg::data_t         i_wdata,
    input  wire logic                       i_rd_en,
    input  wire logic [RAM_ADDR_BITS-1:0]   i_rd_addr,
    output soc_bus_pkg::data_t              o_rdata
);

    import soc_bus_pkg::*;

    data_t mem [2**RAM_ADDR_BITS];

    data_t rd_q;            // Registered array read
    logic  byp_hit_q;       // Read collided with a write
    strb_t byp_strb_q;
    data_t byp_data_q;

    // Byte-lane write in the data phase
    always_ff @(posedge clk)
    begin
        if (i_sel && i_wr_en)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (i_strb[b])
                    mem[i_word_addr][b*8 +: 8] <= i_wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (i_rd_en)
            rd_q <= mem[i_rd_addr];
        byp_strb_q <= i_strb;
        byp_data_q <= i_wdata;
    end

    // ------------------------------
    // Back-to-back bypass
    // ------------------------------
    always_ff @(posedge clk or negedge RSTn)
    begin
        if (!RSTn)
            byp_hit_q <= 1'b0;
        else
            byp_hit_q <= i_rd_en && i_sel && i_wr_en && (i_word_addr == i_rd_addr);
    end

    // Freshly written bytes override the stale array word
    always_comb
    begin
        for (int b = 0; b < 4; b++)
        begin
            o_rdata[b*8 +: 8] = (byp_hit_q && byp_strb_q[b]) ? byp_data_q[b*8 +: 8]
                                                             : rd_q[b*8 +: 8];
        end
    end

endmodule

`default_nettype wire

// File: hw/soc_bus_pkg.sv
// AHB-Lite, 32-bit address and data, little-endian byte lanes, two slave regions only
`default_nettype none

package soc_bus_pkg;

    // ------------------------------
    // Bus widths
    // ------------------------------
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;        // One strobe per byte lane

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [1:0]        htrans_t;
    typedef logic [2:0]        hsize_t;
    typedef logic [7:0]        region_t;       // Top address byte

    // Transfer types, SEQ (2'b11) also counts as a transfer
    localparam htrans_t HTRANS_IDLE   = 2'b00;
    localparam htrans_t HTRANS_NONSEQ = 2'b10;

    // Transfer sizes
    localparam hsize_t HSIZE_BYTE = 3'd0;
    localparam hsize_t HSIZE_HALF = 3'd1;
    localparam hsize_t HSIZE_WORD = 3'd2;

    // ------------------------------
    // Region map
    // ------------------------------
    localparam region_t REGION_RAM  = 8'h20;
    localparam region_t REGION_GPIO = 8'h40;

    // GPIO register word offsets
    localparam logic [3:0] GPIO_REG_OUT = 4'd0;
    localparam logic [3:0] GPIO_REG_OE  = 4'd1;
    localparam logic [3:0] GPIO_REG_IN  = 4'd2;

endpackage

`default_nettype wire

// File: hw/soc_periph_top.sv
// AHB-Lite slave only, no HBURST/HPROT/HMASTLOCK; RAM_ADDR_BITS >= 4, GPIO_WIDTH 1..32
`timescale 1ns/1ps
`default_nettype none

module soc_periph_top #(
    parameter int RAM_ADDR_BITS = 10,   // 4 KiB
    parameter int GPIO_WIDTH    = 32
) (
    input  wire logic                   clk,
    input  wire logic                   RSTn,
    input  wire soc_bus_pkg::addr_t     i_haddr,
    input  wire soc_bus_pkg::htrans_t   i_htrans,
    input  wire logic                   i_hwrite,
    input  wire soc_bus_pkg::hsize_t    i_hsize,
    input  wire soc_bus_pkg::data_t     i_hwdata,
    input  wire logic [GPIO_WIDTH-1:0]  i_gpio_in,
    output soc_bus_pkg::data_t          o_hrdata,
    output logic                        o_hready,
    output logic                        o_hresp,
    output logic [GPIO_WIDTH-1:0]       o_gpio_out,
    output logic [GPIO_WIDTH-1:0]       o_gpio_oe
);

    import soc_bus_pkg::*;

    // Data phase controls
    logic                     ram_sel;
    logic                     gpio_sel;
    logic                     err_sel;
    logic                     wr_en;
    strb_t                    strb;
    logic [RAM_ADDR_BITS-1:0] word_addr;

    // Address phase RAM read
    logic                     ram_rd_en;
    logic [RAM_ADDR_BITS-1:0] ram_rd_addr;

    data_t                    ram_rdata;
    data_t                    gpio_rdata;

    // ------------------------------
    // Decode
    // ------------------------------
    ahb_addr_decode #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) addr_decode_i (
        .clk           (clk),
        .RSTn          (RSTn),
        .i_haddr       (i_haddr),
        .i_htrans      (i_htrans),
        .i_hwrite      (i_hwrite),
        .i_hsize       (i_hsize),
        .i_hready      (o_hready),      // Slave is the only stall source
        .o_ram_sel     (ram_sel),
        .o_gpio_sel    (gpio_sel),
        .o_err_sel     (err_sel),
        .o_wr_en       (wr_en),
        .o_strb        (strb),
        .o_word_addr   (word_addr),
        .o_ram_rd_en   (ram_rd_en),
        .o_ram_rd_addr (ram_rd_addr)
    );

    // ------------------------------
    // Slaves
    // ------------------------------
    ahb_sram #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS)
    ) sram_i (
        .clk         (clk),
        .RSTn        (RSTn),
        .i_sel       (ram_sel),
        .i_wr_en     (wr_en),
        .i_strb      (strb),
        .i_word_addr (word_addr),
        .i_wdata     (i_hwdata),
        .i_rd_en     (ram_rd_en),
        .i_rd_addr   (ram_rd_addr),
        .o_rdata     (ram_rdata)
    );

    ahb_gpio #(
        .GPIO_WIDTH (GPIO_WIDTH)
    ) gpio_i (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_sel      (gpio_sel),
        .i_wr_en    (wr_en),
        .i_strb     (strb),
        .i_reg_addr (word_addr[3:0]),   // Register word offset
        .i_wdata    (i_hwdata),
        .i_gpio_in  (i_gpio_in),
        .o_rdata    (gpio_rdata),
        .o_gpio_out (o_gpio_out),
        .o_gpio_oe  (o_gpio_oe)
    );

    // Read data and response
    ahb_resp_mux resp_mux_i (
        .clk          (clk),
        .RSTn         (RSTn),
        .i_ram_sel    (ram_sel),
        .i_gpio_sel   (gpio_sel),
        .i_err_sel    (err_sel),
        .i_ram_rdata  (ram_rdata),
        .i_gpio_rdata (gpio_rdata),
        .o_hrdata     (o_hrdata),
        .o_hready     (o_hready),
        .o_hresp      (o_hresp)
    );

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
// Free-running clock from time zero, RSTn held low for RESET_CYCLES rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 5,     // 10 ns period
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic RSTn
);

    initial
    begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial
    begin
        RSTn = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        RSTn <= 1'b1;                   // Release on a clock edge
    end

endmodule

`default_nettype wire

// File: tests/tb_soc_periph.sv
// Single AHB master model, one transfer at a time except the back-to-back bypass case
`timescale 1ns/1ps
`default_nettype none

module tb_soc_periph;

    import soc_bus_pkg::*;

    localparam int RAM_ADDR_BITS = 10;
    localparam int GPIO_WIDTH    = 32;
    localparam int WAIT_LIMIT    = 16;  // Cycles before a wait gives up

    logic                  clk;
    logic                  RSTn;
    addr_t                 haddr;
    htrans_t               htrans;
    logic                  hwrite;
    hsize_t                hsize;
    data_t                 hwdata;
    logic [GPIO_WIDTH-1:0] gpio_in;
    data_t                 hrdata;
    logic                  hready;
    logic                  hresp;
    logic [GPIO_WIDTH-1:0] gpio_out;
    logic [GPIO_WIDTH-1:0] gpio_oe;

    data_t       ram_model [2**RAM_ADDR_BITS];
    logic [31:0] lfsr_q = 32'h349aa25f;
    int          checks = 0;
    int          errors = 0;

    tb_clk_gen clk_gen_i (
        .clk  (clk),
        .RSTn (RSTn)
    );

    soc_periph_top #(
        .RAM_ADDR_BITS (RAM_ADDR_BITS),
        .GPIO_WIDTH    (GPIO_WIDTH)
    ) dut_i (
        .clk        (clk),
        .RSTn       (RSTn),
        .i_haddr    (haddr),
        .i_htrans   (htrans),
        .i_hwrite   (hwrite),
        .i_hsize    (hsize),
        .i_hwdata   (hwdata),
        .i_gpio_in  (gpio_in),
        .o_hrdata   (hrdata),
        .o_hready   (hready),
        .o_hresp    (hresp),
        .o_gpio_out (gpio_out),
        .o_gpio_oe  (gpio_oe)
    );

    // ------------------------------
    // Helpers
    // ------------------------------
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0])
            n = n ^ 32'h8020_0003;      // Taps 32, 22, 2, 1
        return n;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_next(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // Bytes covered by a transfer, low address bits under the size dropped
    function automatic data_t lane_mask(input hsize_t size, input logic [1:0] off);
        data_t m;
        int    nbytes;
        int    lo;
        m      = '0;
        nbytes = 1 << size;
        lo     = int'(off) & ~(nbytes - 1);
        for (int b = 0; b < 4; b++)
        begin
            if (b >= lo && b < lo + nbytes)
                m[b*8 +: 8] = 8'hFF;
        end
        return m;
    endfunction

    function automatic addr_t gpio_addr(input logic [3:0] reg_off, input logic [1:0] byte_off);
        return {REGION_GPIO, 18'h0, reg_off, byte_off};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] got);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("ERR t=%0t %s expected=0x%08h got=0x%08h", $time, name, expected, got);
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timeout waiting for %s, %0d checks, %0d errors",
                 what, checks, errors);
        $display("TEST RESULT: FAIL");
        $finish;
    endtask

    task automatic wait_hready(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (!hready)
        begin
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run({"HREADY in ", what});
            @(negedge clk);
        end
    endtask

    // ------------------------------
    // Bus master
    // ------------------------------
    task automatic transfer(input addr_t addr, input logic write, input hsize_t size,
                            input data_t wdata, output data_t rdata, output logic resp,
                            output int stalls, output logic stall_resp);
        int waited;
        stalls     = 0;
        stall_resp = 1'b1;
        @(posedge clk);
        haddr  <= addr;
        htrans <= HTRANS_NONSEQ;
        hwrite <= write;
        hsize  <= size;
        wait_hready("address phase");
        @(posedge clk);                 // Address accepted
        htrans <= HTRANS_IDLE;
        hwdata <= write ? wdata : '0;
        waited = 0;
        @(negedge clk);
        while (!hready)
        begin
            stalls++;
            stall_resp = stall_resp & hresp;
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("HREADY in data phase");
            @(negedge clk);
        end
        rdata = hrdata;
        resp  = hresp;
    endtask

    // Mapped slaves answer with zero wait states
    task automatic bus_write(input addr_t addr, input hsize_t size, input data_t data,
                             output logic resp);
        data_t ignored_rdata;
        int    stalls;
        logic  stall_resp;
        transfer(addr, 1'b1, size, data, ignored_rdata, resp, stalls, stall_resp);
        check_eq("wait states", 32'd0, 32'(stalls));
    endtask

    task automatic bus_read(input addr_t addr, output data_t data, output logic resp);
        int   stalls;
        logic stall_resp;
        transfer(addr, 1'b0, HSIZE_WORD, '0, data, resp, stalls, stall_resp);
        check_eq("wait states", 32'd0, 32'(stalls));
    endtask

    // Read address phase overlaps the write data phase
    task automatic write_then_read(input addr_t addr, input data_t wdata, output data_t rdata);
        @(posedge clk);
        haddr  <= addr;
        htrans <= HTRANS_NONSEQ;
        hwrite <= 1'b1;
        hsize  <= HSIZE_WORD;
        wait_hready("write address phase");
        @(posedge clk);
        hwdata <= wdata;
        hwrite <= 1'b0;
        wait_hready("write data phase");
        @(posedge clk);
        htrans <= HTRANS_IDLE;
        wait_hready("read data phase");
        rdata = hrdata;
    endtask

    task automatic ram_write(input addr_t addr, input hsize_t size, input data_t data);
        data_t                    m;
        logic                     resp;
        logic [RAM_ADDR_BITS-1:0] idx;
        m   = lane_mask(size, addr[1:0]);
        idx = addr[RAM_ADDR_BITS+1:2];
        bus_write(addr, size, data, resp);
        check_eq("o_hresp", 32'd0, 32'(resp));
        ram_model[idx] = (ram_model[idx] & ~m) | (data & m);
    endtask

    task automatic ram_read_check(input addr_t addr);
        data_t rdata;
        logic  resp;
        bus_read(addr, rdata, resp);
        check_eq("o_hresp", 32'd0, 32'(resp));
        check_eq("o_hrdata", ram_model[addr[RAM_ADDR_BITS+1:2]], rdata);
    endtask

    task automatic gpio_read_check(input logic [3:0] reg_off, input data_t expected);
        data_t rdata;
        logic  resp;
        bus_read(gpio_addr(reg_off, 2'd0), rdata, resp);
        check_eq("o_hresp", 32'd0, 32'(resp));
        check_eq("o_hrdata", expected, rdata);
    endtask

    // ------------------------------
    // Tests
    // ------------------------------
    task automatic test_reset();
        int waited;
        waited = 0;
        while (RSTn !== 1'b1)
        begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run("reset release");
        end
        @(negedge clk);
        check_eq("o_hready", 32'd1, 32'(hready));
        check_eq("o_hresp", 32'd0, 32'(hresp));
        check_eq("o_gpio_out", 32'd0, 32'(gpio_out));
        check_eq("o_gpio_oe", 32'd0, 32'(gpio_oe));
    endtask

    task automatic test_ram_words();
        addr_t addrs [8];
        logic [31:0] r;
        data_t wdata;
        data_t rdata;
        for (int i = 0; i < 8; i++)
        begin
            r = rand_bits(22);
            addrs[i] = {REGION_RAM, r[21:0], 2'b00};   // High bits alias
            ram_write(addrs[i], HSIZE_WORD, rand_bits(32));
        end
        for (int i = 0; i < 8; i++)
            ram_read_check(addrs[i]);
        // Bypass path
        r     = rand_bits(22);
        wdata = rand_bits(32);
        write_then_read({REGION_RAM, r[21:0], 2'b00}, wdata, rdata);
        ram_model[r[RAM_ADDR_BITS-1:0]] = wdata;
        check_eq("o_hrdata", wdata, rdata);
    endtask

    task automatic test_byte_lanes();
        addr_t base;
        base = 32'h2000_0100;
        ram_write(base, HSIZE_WORD, rand_bits(32));
        for (int off = 0; off < 4; off++)
        begin
            ram_write(base + off, HSIZE_BYTE, rand_bits(32));
            ram_read_check(base);
        end
        for (int off = 0; off < 4; off++)   // Odd offsets fold onto the aligned half
        begin
            ram_write(base + off, HSIZE_HALF, rand_bits(32));
            ram_read_check(base);
        end
    endtask

    task automatic test_gpio();
        data_t out_val;
        data_t oe_val;
        data_t byte_val;
        data_t byte_mask;
        data_t in_val;
        logic  resp;
        out_val = rand_bits(32);
        oe_val  = rand_bits(32);
        bus_write(gpio_addr(GPIO_REG_OUT, 2'd0), HSIZE_WORD, out_val, resp);
        check_eq("o_hresp", 32'd0, 32'(resp));
        bus_write(gpio_addr(GPIO_REG_OE, 2'd0), HSIZE_WORD, oe_val, resp);
        check_eq("o_hresp", 32'd0, 32'(resp));
        gpio_read_check(GPIO_REG_OUT, out_val);
        gpio_read_check(GPIO_REG_OE, oe_val);
        check_eq("o_gpio_out", out_val, 32'(gpio_out));
        check_eq("o_gpio_oe", oe_val, 32'(gpio_oe));
        // Lane 1 only
        byte_val = rand_bits(32);
        bus_write(gpio_addr(GPIO_REG_OUT, 2'd1), HSIZE_BYTE, byte_val, resp);
        check_eq("o_hresp", 32'd0, 32'(resp));
        byte_mask = lane_mask(HSIZE_BYTE, 2'd1);
        out_val   = (out_val & ~byte_mask) | (byte_val & byte_mask);
        gpio_read_check(GPIO_REG_OUT, out_val);
        check_eq("o_gpio_out", out_val, 32'(gpio_out));
        // Input pins through the synchronizer
        in_val = rand_bits(32);
        @(posedge clk);
        gpio_in <= in_val[GPIO_WIDTH-1:0];
        repeat (3) @(posedge clk);
        gpio_read_check(GPIO_REG_IN, in_val);
        gpio_read_check(4'd3, 32'd0);       // Unused offset
    endtask

    task automatic test_unmapped();
        data_t rdata;
        logic  resp;
        int    stalls;
        logic  stall_resp;
        transfer(32'h1000_0040, 1'b0, HSIZE_WORD, '0, rdata, resp, stalls, stall_resp);
        check_eq("error wait states", 32'd1, 32'(stalls));
        check_eq("o_hresp (hready low)", 32'd1, 32'(stall_resp));
        check_eq("o_hresp (hready high)", 32'd1, 32'(resp));
        ram_read_check(32'h2000_0100);
    endtask

    initial
    begin
        haddr   <= '0;
        htrans  <= HTRANS_IDLE;
        hwrite  <= 1'b0;
        hsize   <= HSIZE_WORD;
        hwdata  <= '0;
        gpio_in <= '0;
        test_reset();
        test_ram_words();
        test_byte_lanes();
        test_gpio();
        test_unmapped();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
hw/soc_bus_pkg.sv
hw/ahb_addr_decode.sv
hw/ahb_sram.sv
hw/ahb_gpio.sv
hw/ahb_resp_mux.sv
hw/soc_periph_top.sv
tests/tb_clk_gen.sv
tests/tb_soc_periph.sv
